// File: rtl/traceEchoPkg.sv
// shared widths, frame layout constants and the trace word decode used across the echo engine RTL
package traceEchoPkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////
  localparam int WORD_BITS  = 32;
  localparam int COUNT_BITS = 10;  // beat counter and record pointer
  localparam int BANK_WORDS = 128;
  localparam int ADDR_BITS  = 7;
  localparam int LEN_BITS   = 8;   // holds 0 to BANK_WORDS

  ////////////////////////////////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////////////////////////////////
  localparam int HEADER_WORDS       = 4;   // copied unchanged
  localparam int KEEP_WORDS         = 5;   // stored per record
  localparam int CSR_COUNT_OFFSET   = 9;
  localparam int REG_EN_OFFSET      = 10;
  localparam int RECORD_BASE_LEN    = 12;
  localparam int CSR_EXTRA_LEN      = 13;  // csr block present
  localparam int REG_EXTRA_LEN      = 2;   // gpr or fpr write present
  localparam int INTER_PACKET_DELAY = 1;   // replaces record beat 4

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [LEN_BITS-1:0]  len_t;

  // one record beat, read as csr count or as register enables depending on offset
  typedef union packed {
    struct packed {
      logic [15:0] unused;
      logic [15:0] csrCount;
    } csrView;
    struct packed {
      logic [22:0] reservedHi;
      logic        gprEn;       // bit 8
      logic [6:0]  reservedLo;
      logic        fprEn;       // bit 0
    } regEnView;
  } traceWord_u;

endpackage

// File: rtl/frameIfs.sv
// write and read side interfaces between the capture FSM, the two-bank buffer and the transmitter
`timescale 1ns/100ps

// capture -> buffer, one write per kept beat plus the end-of-frame pulse
interface frameWriteIf import traceEchoPkg::*; ();
  logic                  wrEn;
  logic [COUNT_BITS-1:0] wrAddr;     // may run past the bank, buffer drops those
  word_t                 wrData;
  logic                  frameDone;  // one cycle, beat after last
  logic [COUNT_BITS-1:0] frameLen;
  logic                  bankFree;

  modport capture (
    output wrEn, wrAddr, wrData, frameDone, frameLen,
    input  bankFree
  );
  modport store (
    input  wrEn, wrAddr, wrData, frameDone, frameLen,
    output bankFree
  );
endinterface

// buffer -> transmitter, combinational read of the send bank
interface frameReadIf import traceEchoPkg::*; ();
  word_t rdData;
  logic  frameReady;  // level, send bank full
  len_t  rdLen;
  addr_t rdAddr;
  logic  frameTaken;  // one cycle, frees the send bank

  modport store (
    output rdData, frameReady, rdLen,
    input  rdAddr, frameTaken
  );
  modport send (
    input  rdData, frameReady, rdLen,
    output rdAddr, frameTaken
  );
endinterface

// File: rtl/recordCapture.sv
// receive FSM that walks frame header and trace records and writes the kept beats into the buffer
`timescale 1ns/100ps

module recordCapture import traceEchoPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  rxData,
  input  logic   rxValid,
  input  logic   rxLast,
  output logic   frameLost,
  frameWriteIf.capture wr
);

  enum logic [1:0] {stIdle, stCapture, stDone} state, nextState;

  logic [COUNT_BITS-1:0] beatCount;   // index of next beat in frame
  logic [COUNT_BITS-1:0] beatIdx;
  logic [COUNT_BITS-1:0] recPtr;      // first beat of current record
  logic [COUNT_BITS-1:0] recOffset;
  logic [COUNT_BITS-1:0] recLen;
  logic [COUNT_BITS-1:0] storeCount;
  logic [COUNT_BITS-1:0] doneLen;
  logic [15:0]           csrSaved;
  traceWord_u            rxWord;
  logic                  frameStart;
  logic                  dropping;
  logic                  dropNow;
  logic                  frameKept;
  logic                  inRecord;
  logic                  keepBeat;

  ////////////////////////////////////////////////////////////////////
  // frame tracking
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      stIdle, stDone: begin
        if (rxValid) nextState = rxLast ? stDone : stCapture;
        else nextState = stIdle;
      end
      stCapture: if (rxValid && rxLast) nextState = stDone;
      default: nextState = stIdle;
    endcase
  end

  assign beatIdx    = (state == stCapture) ? beatCount : '0;
  assign frameStart = rxValid && (state != stCapture);
  // the bank decision is taken once on the first beat and then held
  assign dropNow    = frameStart ? ~wr.bankFree : dropping;

  ////////////////////////////////////////////////////////////////////
  // record walk
  ////////////////////////////////////////////////////////////////////
  assign rxWord    = rxData;
  assign recOffset = beatIdx - recPtr;  // wraps large before the record starts
  assign inRecord  = recOffset < COUNT_BITS'(KEEP_WORDS);
  assign keepBeat  = (beatIdx < COUNT_BITS'(HEADER_WORDS)) || inRecord;

  // length known once the enable word arrives, csr count saved one beat earlier
  always_comb begin
    recLen = COUNT_BITS'(RECORD_BASE_LEN);
    if (csrSaved != '0)
      recLen = recLen + COUNT_BITS'(CSR_EXTRA_LEN);
    if (rxWord.regEnView.gprEn || rxWord.regEnView.fprEn)
      recLen = recLen + COUNT_BITS'(REG_EXTRA_LEN);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= stIdle;
      beatCount  <= '0;
      recPtr     <= COUNT_BITS'(HEADER_WORDS);
      storeCount <= '0;
      dropping   <= 1'b0;
      frameKept  <= 1'b0;
    end else begin
      state <= nextState;
      if (rxValid) begin
        dropping <= dropNow;
        if (rxLast) begin  // ack beat, rewind for next frame
          beatCount  <= '0;
          recPtr     <= COUNT_BITS'(HEADER_WORDS);
          storeCount <= '0;
          frameKept  <= ~dropNow;
        end else begin
          beatCount <= beatIdx + 1'b1;
          if (wr.wrEn) storeCount <= storeCount + 1'b1;
          if (recOffset == COUNT_BITS'(REG_EN_OFFSET)) recPtr <= recPtr + recLen;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rxValid && recOffset == COUNT_BITS'(CSR_COUNT_OFFSET))
      csrSaved <= rxWord.csrView.csrCount;
    if (rxValid && rxLast)
      doneLen <= storeCount;
  end

  ////////////////////////////////////////////////////////////////////
  // buffer writes
  ////////////////////////////////////////////////////////////////////
  assign wr.wrEn   = rxValid && !rxLast && keepBeat && !dropNow;
  assign wr.wrAddr = storeCount;

  always_comb begin
    wr.wrData = rxData;
    if (inRecord) begin
      if (recOffset == COUNT_BITS'(2) || recOffset == COUNT_BITS'(3))
        wr.wrData = '0;                             // beats 2 and 3 cleared
      else if (recOffset == COUNT_BITS'(4))
        wr.wrData = word_t'(INTER_PACKET_DELAY);
    end
  end

  assign wr.frameDone = (state == stDone) && frameKept;
  assign wr.frameLen  = doneLen;
  assign frameLost    = rxValid && rxLast && dropNow;  // no bank was free at frame start

endmodule

// File: rtl/frameBuffer.sv
// two-bank frame store, one bank filled by capture while the other is read out by the transmitter
`timescale 1ns/100ps

module frameBuffer import traceEchoPkg::*; (
  input  logic clk,
  input  logic reset,
  frameWriteIf.store wr,
  frameReadIf.store  rd
);

  word_t      bankMem [0:1][0:BANK_WORDS-1];
  len_t       bankLen [0:1];
  logic [1:0] bankFull;
  logic       fillBank;
  logic       sendBank;
  logic       writeBank;
  len_t       capLen;

  // a new frame may begin while frameDone closes the old one, so steer to the next bank
  assign writeBank = wr.frameDone ? ~fillBank : fillBank;

  // words past the bank are discarded, length clipped to match
  assign capLen = (wr.frameLen > COUNT_BITS'(BANK_WORDS)) ? len_t'(BANK_WORDS)
                                                          : len_t'(wr.frameLen);

  ////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr.wrEn && wr.wrAddr < COUNT_BITS'(BANK_WORDS))
      bankMem[writeBank][wr.wrAddr[ADDR_BITS-1:0]] <= wr.wrData;
    if (wr.frameDone)
      bankLen[fillBank] <= capLen;
  end

  ////////////////////////////////////////////////////////////////////
  // bank ownership
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      bankFull <= 2'b00;
      fillBank <= 1'b0;
      sendBank <= 1'b0;
    end else begin
      if (wr.frameDone) begin
        bankFull[fillBank] <= 1'b1;
        fillBank           <= ~fillBank;
      end
      if (rd.frameTaken) begin   // never the bank frameDone is closing
        bankFull[sendBank] <= 1'b0;
        sendBank           <= ~sendBank;
      end
    end
  end

  assign wr.bankFree = ~bankFull[writeBank];

  assign rd.frameReady = bankFull[sendBank];
  assign rd.rdLen      = bankLen[sendBank];
  assign rd.rdData     = bankMem[sendBank][rd.rdAddr];  // combinational read

endmodule

// File: rtl/echoTransmitter.sv
// transmit FSM that streams a full bank out word by word under ready back-pressure
`timescale 1ns/100ps

module echoTransmitter import traceEchoPkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t txData,
  output logic  txValid,
  output logic  txLast,
  input  logic  txReady,
  frameReadIf.send rd
);

  enum logic [1:0] {stReady, stSend, stFinished} state, nextState;

  len_t readCount;  // word on the bus
  logic lastWord;

  assign lastWord = (readCount + 1'b1) == rd.rdLen;

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      stReady: begin
        if (rd.frameReady)
          nextState = (rd.rdLen == '0) ? stFinished : stSend;  // empty frame freed directly
      end
      stSend:     if (txReady && lastWord) nextState = stFinished;
      stFinished: nextState = stReady;
      default:    nextState = stReady;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= stReady;
      readCount <= '0;
    end else begin
      state <= nextState;
      if (state == stSend && txReady)
        readCount <= lastWord ? '0 : readCount + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stream outputs
  ////////////////////////////////////////////////////////////////////
  // counter only moves on txReady, so data and last hold while stalled
  assign rd.rdAddr = readCount[ADDR_BITS-1:0];
  assign txData    = rd.rdData;
  assign txValid   = (state == stSend);
  assign txLast    = txValid && lastWord;

  assign rd.frameTaken = (state == stFinished);  // bank released on this edge

endmodule

// File: rtl/traceEcho.sv
// top of the trace frame echo engine, joins capture, two-bank buffer and transmitter
`timescale 1ns/100ps

module traceEcho import traceEchoPkg::*; (
  input  logic  clk,
  input  logic  reset,
  // receive stream, no ready
  input  word_t rxData,
  input  logic  rxValid,
  input  logic  rxLast,
  // transmit stream
  output word_t txData,
  output logic  txValid,
  output logic  txLast,
  input  logic  txReady,
  output logic  frameLost   // pulse per dropped frame
);

  frameWriteIf wrBus ();
  frameReadIf  rdBus ();

  ////////////////////////////////////////////////////////////////////
  // receive and store
  ////////////////////////////////////////////////////////////////////
  recordCapture capture (
    .clk       (clk),
    .reset     (reset),
    .rxData    (rxData),
    .rxValid   (rxValid),
    .rxLast    (rxLast),
    .frameLost (frameLost),
    .wr        (wrBus.capture)
  );

  frameBuffer buffer (
    .clk   (clk),
    .reset (reset),
    .wr    (wrBus.store),
    .rd    (rdBus.store)
  );

  ////////////////////////////////////////////////////////////////////
  // send back
  ////////////////////////////////////////////////////////////////////
  echoTransmitter transmitter (
    .clk     (clk),
    .reset   (reset),
    .txData  (txData),
    .txValid (txValid),
    .txLast  (txLast),
    .txReady (txReady),
    .rd      (rdBus.send)
  );

endmodule

// File: bench/echoModel.svh
// capture rule model, bank occupancy and compare tasks, included into the echo testbench top
  ////////////////////////////////////////////////////////////////////
  // capture rule
  ////////////////////////////////////////////////////////////////////
  // walks frameBeats and leaves the words the engine should keep in keptWords
  function automatic void applyCaptureRule();
    int ptr;     // first beat of current record
    int ofs;
    int recLen;
    keptWords.delete();
    ptr = HEADER_WORDS;
    for (int i = 0; i < frameBeats.size() - 1; i++) begin  // last beat is the ack
      ofs = i - ptr;
      if (i < HEADER_WORDS) begin
        keptWords.push_back(frameBeats[i]);
      end else if (ofs >= 0 && ofs < KEEP_WORDS) begin
        if (ofs == 2 || ofs == 3) keptWords.push_back(word_t'(0));
        else if (ofs == 4) keptWords.push_back(word_t'(INTER_PACKET_DELAY));
        else keptWords.push_back(frameBeats[i]);
      end
      if (ofs == REG_EN_OFFSET) begin
        recLen = RECORD_BASE_LEN;
        if (frameBeats[ptr + CSR_COUNT_OFFSET][15:0] != 16'h0) recLen += CSR_EXTRA_LEN;
        if (frameBeats[i][0] || frameBeats[i][8]) recLen += REG_EXTRA_LEN;  // fpr or gpr
        ptr += recLen;
      end
    end
    while (keptWords.size() > BANK_WORDS) keptWords.pop_back();  // past the bank
  endfunction

  // frame start, lost when both banks still hold frames
  function automatic void modelFrameStart();
    applyCaptureRule();
    if (banksBusy >= 2) begin
      lostExpected++;
    end else begin
      banksBusy++;
      foreach (keptWords[i]) expWords.push_back(keptWords[i]);
      expLens.push_back(len_t'(keptWords.size()));
    end
  endfunction

  ////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////
  task automatic checkWord(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input len_t got, input len_t exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

// File: bench/traceEchoTb.sv
// testbench top that drives random trace frames into the echo engine and checks the echo against the capture model
`timescale 1ns/100ps

module traceEchoTb import traceEchoPkg::*; ();

  localparam int DRAIN_LIMIT = 5000;  // cycles per drain wait

  typedef enum {readyHigh, readyRandom, readyLow} readyMode_e;

  logic       clk;
  logic       reset;
  word_t      rxData;
  logic       rxValid;
  logic       rxLast;
  word_t      txData;
  logic       txValid;
  logic       txLast;
  logic       txReady;
  logic       frameLost;
  readyMode_e readyMode;

  word_t frameBeats[$];
  word_t keptWords[$];
  word_t expWords[$];   // flat expected stream
  len_t  expLens[$];    // words per expected frame
  int    banksBusy;
  int    lostExpected;
  int    lostSeen;
  int    errorCount;
  int    testsRun;
  int    testsFailed;
  int    framesEchoed;
  int    wordsInFrame;
  bit    timedOut;
  bit    stalled;
  word_t heldData;

  `include "echoModel.svh"

  traceEcho DUT (
    .clk       (clk),
    .reset     (reset),
    .rxData    (rxData),
    .rxValid   (rxValid),
    .rxLast    (rxLast),
    .txData    (txData),
    .txValid   (txValid),
    .txLast    (txLast),
    .txReady   (txReady),
    .frameLost (frameLost)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    case (readyMode)
      readyRandom: txReady <= 1'($urandom_range(1));
      readyLow:    txReady <= 1'b0;
      default:     txReady <= 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // transmit monitor and scoreboard
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!reset) begin
      if (stalled) begin
        if (!txValid) begin
          errorCount++;
          $display("error at %0t: txValid dropped while txReady was low", $time);
        end
        checkWord(txData, heldData, "txData during stall");
      end
      stalled  = txValid && !txReady;
      heldData = txData;
      if (frameLost) lostSeen++;
      if (txValid && txReady) begin
        wordsInFrame++;
        if (expWords.size() == 0) begin
          errorCount++;
          $display("error at %0t: word %h sent with no frame expected", $time, txData);
        end else begin
          checkWord(txData, expWords.pop_front(), "echoed word");
        end
        if (txLast) begin
          if (expLens.size() != 0) checkCount(len_t'(wordsInFrame), expLens.pop_front(),
                                              "words in frame");
          wordsInFrame = 0;
          banksBusy--;  // bank goes back once the frame is out
          framesEchoed++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  // builds the header, nRec records and the ack beat
  // mode picks the record kinds as plain (0), cycling (1) or random (2)
  task automatic makeFrame(input int nRec, input int mode);
    int    kind;  // bit 0 csr block, bit 1 register write
    int    recLen;
    word_t word;
    frameBeats.delete();
    repeat (HEADER_WORDS) frameBeats.push_back($urandom);
    for (int r = 0; r < nRec; r++) begin
      kind   = (mode == 0) ? 0 : (mode == 1) ? r % 4 : $urandom_range(3);
      recLen = RECORD_BASE_LEN + (kind[0] ? CSR_EXTRA_LEN : 0) + (kind[1] ? REG_EXTRA_LEN : 0);
      for (int o = 0; o < recLen; o++) begin
        word = $urandom;
        if (o == CSR_COUNT_OFFSET) word[15:0] = kind[0] ? 16'($urandom_range(16'hffff, 1)) : 16'h0;
        if (o == REG_EN_OFFSET) begin
          word[0] = kind[1] && ($urandom_range(2) != 1);
          word[8] = kind[1] && !word[0] ? 1'b1 : kind[1] && $urandom_range(1);
        end
        frameBeats.push_back(word);
      end
    end
    frameBeats.push_back($urandom);  // ack
  endtask

  task automatic sendFrame();
    modelFrameStart();
    foreach (frameBeats[i]) begin
      @(posedge clk);
      rxData  <= frameBeats[i];
      rxValid <= 1'b1;
      rxLast  <= (i == frameBeats.size() - 1);
    end
  endtask

  task automatic endRxStream();
    @(posedge clk);
    rxValid <= 1'b0;
    rxLast  <= 1'b0;
  endtask

  task automatic waitDrain();
    int cycles;
    if (timedOut) return;
    cycles = 0;
    while (expLens.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (expLens.size() != 0) begin
      timedOut = 1'b1;
      $display("timeout at %0t: %0d frames were never echoed", $time, expLens.size());
    end
    repeat (2) @(posedge clk);  // frameTaken frees the bank
  endtask

  task automatic runTest(input int n);
    int    errorsBefore;
    string name;
    bit    testFailed;
    errorsBefore = errorCount;
    lostExpected = 0;
    lostSeen     = 0;
    readyMode    = readyHigh;
    case (n)
      1: begin
        name = "header-only frame";
        makeFrame(0, 0);
        sendFrame();
        endRxStream();
      end
      2: begin
        name = "plain records, zero and delay rewrite";
        makeFrame(5, 0);
        sendFrame();
        endRxStream();
      end
      3: begin
        name = "csr and register skips";
        makeFrame(8, 1);
        sendFrame();
        endRxStream();
      end
      4: begin
        name = "random frames, random txReady";
        readyMode = readyRandom;
        for (int p = 0; p < 6; p++) begin
          makeFrame($urandom_range(6), 2);
          sendFrame();
          makeFrame((p == 5) ? 30 : $urandom_range(6), (p == 5) ? 0 : 2);  // last overflows
          sendFrame();
          endRxStream();
          waitDrain();
        end
      end
      5: begin
        name = "back to back frames";
        makeFrame(10, 2);
        sendFrame();
        makeFrame(10, 2);
        sendFrame();
        endRxStream();
      end
      default: begin
        name = "third frame lost under stall";
        readyMode = readyLow;
        repeat (3) begin
          makeFrame(4, 2);
          sendFrame();
          endRxStream();
        end
        repeat (4) @(posedge clk);
        readyMode = readyHigh;
      end
    endcase
    waitDrain();
    checkCount(len_t'(lostSeen), len_t'(lostExpected), "frameLost pulses");
    testsRun++;
    testFailed = (errorCount != errorsBefore) || timedOut;
    if (testFailed) testsFailed++;
    $display("test %0d %s: %s", n, name, testFailed ? "FAILED" : "ok");
  endtask

  initial begin
    void'($urandom(32'h9f84));
    clk = 1'b0;
    reset = 1'b1;
    rxData = '0;
    rxValid = 1'b0;
    rxLast = 1'b0;
    txReady = 1'b0;
    readyMode = readyHigh;
    banksBusy = 0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    framesEchoed = 0;
    wordsInFrame = 0;
    timedOut = 1'b0;
    stalled = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int t = 1; t <= 6 && !timedOut; t++) runTest(t);
    $display("tests run %0d, failed %0d, frames echoed %0d, errors %0d",
             testsRun, testsFailed, framesEchoed, errorCount);
    if (errorCount == 0 && !timedOut)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+bench
rtl/traceEchoPkg.sv
rtl/frameIfs.sv
rtl/recordCapture.sv
rtl/frameBuffer.sv
rtl/echoTransmitter.sv
rtl/traceEcho.sv
bench/traceEchoTb.sv

// File: Bender.yml
package:
  name: trace_echo

sources:
  - rtl/traceEchoPkg.sv
  - rtl/frameIfs.sv
  - rtl/recordCapture.sv
  - rtl/frameBuffer.sv
  - rtl/echoTransmitter.sv
  - rtl/traceEcho.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/traceEchoTb.sv
